// File: dv/tb_sha256_ref.svh
`ifndef TB_SHA256_REF_SVH
`define TB_SHA256_REF_SVH

// ------------------------------
// SHA-256 model built straight from the standard

function automatic word_t ror32(word_t x, int unsigned n);
  return (x >> n) | (x << (32 - n));
endfunction

// idx-th prime, counting 2 as prime 0
function automatic int unsigned nth_prime(int unsigned idx);
  int unsigned n;
  int unsigned found;
  logic        is_p;
  n     = 1;
  found = 0;
  while (found <= idx) begin
    n++;
    is_p = 1'b1;
    for (int unsigned d = 2; d * d <= n; d++)
      if (n % d == 0) is_p = 1'b0;
    if (is_p) found++;
  end
  return n;
endfunction

// first 32 fraction bits of the k-th root of p, exact integer search
function automatic word_t frac_root(int unsigned p, int unsigned k);
  logic [127:0] n;
  logic [127:0] y;
  logic [127:0] t;
  n = 128'(p) << (32 * k);
  y = '0;
  for (int b = 35; b >= 0; b--) begin
    t = y | (128'(1) << b);
    if (((k == 2) ? t * t : t * t * t) <= n) y = t;  // keep the bit if still under
  end
  return y[31:0];
endfunction

function automatic digest_t init_hash();
  digest_t h;
  for (int i = 0; i < 8; i++)
    h[i] = frac_root(nth_prime(i), 2);    // square roots of the first 8 primes
  return h;
endfunction

// 0x80 marker, zero fill, 64-bit big endian bit length
function automatic void pad_message(input byte unsigned msg[$], output word_t words[$]);
  byte unsigned    b[$];
  longint unsigned bits;
  b    = msg;
  bits = 64'(msg.size()) * 8;
  b.push_back(8'h80);
  while (b.size() % 64 != 56)
    b.push_back(8'h00);
  for (int i = 7; i >= 0; i--)
    b.push_back(8'(bits >> (8 * i)));
  words = {};
  for (int i = 0; i < b.size(); i += 4)
    words.push_back({b[i], b[i+1], b[i+2], b[i+3]});
endfunction

function automatic digest_t sha256_ref(word_t blk[$]);
  word_t   k_tab [64];
  word_t   w [64];
  word_t   v [8];
  digest_t h;
  word_t   s0;
  word_t   s1;
  word_t   t1;
  word_t   t2;
  h = init_hash();
  for (int i = 0; i < 64; i++)
    k_tab[i] = frac_root(nth_prime(i), 3);   // cube roots of the first 64 primes
  for (int b = 0; b < blk.size() / 16; b++) begin
    for (int t = 0; t < 64; t++) begin
      if (t < 16)
        w[t] = blk[16 * b + t];
      else begin
        s0   = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
        s1   = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
      end
    end
    for (int i = 0; i < 8; i++)
      v[i] = h[i];
    for (int t = 0; t < 64; t++) begin
      t1 = v[7] + (ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25))
         + ((v[4] & v[5]) ^ (~v[4] & v[6])) + k_tab[t] + w[t];
      t2 = (ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22))
         + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--)
        v[i] = v[i-1];
      v[4] = v[4] + t1;                        // e = d + t1
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++)
      h[i] = h[i] + v[i];
  end
  return h;
endfunction

`endif

// File: dv/tb_sha256_top.sv
`timescale 1ns/100ps
`include "sha256_defs.svh"

module tb_sha256_top;
  import sha256_pkg::*;
  `include "tb_sha256_ref.svh"

  localparam int unsigned SEED = 32'h1588;
  localparam int ACK_TIMEOUT = 16;      // cycles to wait for an ack
  localparam int POLL_LIMIT  = 1000;    // status reads before giving up
  localparam int MIN_LEN     = 56;      // shortest message that pads to two blocks
  localparam int LEN_SPAN    = 128;     // up to 183 bytes, still three blocks

  logic                      sha256_clk;
  logic                      bus_rstn;
  logic [`SHA256_ADDR_W-1:0] sys_addr_i;
  word_t                     sys_wdata_i;
  logic                      sys_wen_i;
  logic                      sys_ren_i;
  word_t                     sys_rdata_o;
  logic                      sys_ack_o;
  logic                      sys_err_o;
  logic                      activated_o;

  int      errors;
  int      n_checks;
  int      test_no;
  int      errs_before;
  logic    last_err;      // sys_err_o seen with the last ack
  digest_t exp_q [$];     // reference side
  digest_t got_q [$];     // DUT side

  sha256_top dut_i (.*);

  initial begin
    sha256_clk = 1'b0;
    forever #4 sha256_clk = ~sha256_clk;
  end

  // ------------------------------
  // compare tasks
  task automatic check_word(word_t got, word_t exp, string what);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_digest(digest_t got, digest_t exp, string what);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // pairs up expected and read digests
  always @(posedge sha256_clk) begin
    digest_t g;
    digest_t e;
    if (exp_q.size() != 0 && got_q.size() != 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      check_digest(g, e, "digest H7..H0");
    end
  end

  // ------------------------------
  // bus tasks, request held for one cycle
  task automatic bus_access(logic wr, logic [`SHA256_ADDR_W-1:0] addr, word_t wdata,
                            output word_t rdata);
    int n;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(posedge sha256_clk);
    #1;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    n = 1;
    while (!sys_ack_o && n < ACK_TIMEOUT) begin
      @(posedge sha256_clk);
      #1;
      n++;
    end
    if (!sys_ack_o) begin
      errors++;
      $display("timeout: no bus ack for the access to offset %h", addr);
    end else
      check_word(word_t'(n), 32'd1, "ack latency in cycles");  // ack right after the request
    rdata    = sys_rdata_o;
    last_err = sys_err_o;
  endtask

  task automatic bus_read(logic [`SHA256_ADDR_W-1:0] addr, output word_t rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  task automatic bus_write(logic [`SHA256_ADDR_W-1:0] addr, word_t wdata);
    word_t unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic read_digest(output digest_t d);
    for (int i = 0; i < 8; i++)
      bus_read(`SHA256_OFS_HASH_H7 + 20'(4 * (7 - i)), d[i]);   // H7 sits lowest
  endtask

  // hand both sides to the compare process and wait until it is done
  task automatic submit_digest(digest_t got, digest_t exp);
    int n;
    exp_q.push_back(exp);
    got_q.push_back(got);
    n = 0;
    while (got_q.size() != 0 && n < 8) begin
      @(posedge sha256_clk);
      #1;
      n++;
    end
    if (got_q.size() != 0) begin
      errors++;
      $display("the digest compare never ran, the queues were left full");
    end
  endtask

  task automatic finish_test(string name);
    test_no++;
    $display("test %0d %-18s %s", test_no, name, (errors == errs_before) ? "passed" : "FAILED");
    errs_before = errors;
  endtask

  // clear the core, enable it, push the padded words, poll, read back
  task automatic hash_message(byte unsigned msg[$], string what);
    word_t   blk [$];
    word_t   st;
    digest_t got;
    int      polls;
    pad_message(msg, blk);
    bus_write(`SHA256_OFS_SHA_CTRL, 32'h2);     // reset bit, old digest gone
    bus_write(`SHA256_OFS_SHA_CTRL, 32'h1);     // then SHA enable
    foreach (blk[i]) begin
      bus_write(`SHA256_OFS_SHA_PUSH, blk[i]);
      check_word(word_t'(last_err), '0, "push error flag");
    end
    st    = '0;
    polls = 0;
    while ((st & 32'h3) != 32'h3 && polls < POLL_LIMIT) begin   // ready and hash valid
      bus_read(`SHA256_OFS_SHA_STATUS, st);
      polls++;
    end
    if ((st & 32'h3) != 32'h3) begin
      errors++;
      $display("timeout: hash of %s never became ready and valid", what);
    end
    read_digest(got);
    submit_digest(got, sha256_ref(blk));
  endtask

  // ------------------------------
  initial begin
    word_t        rd;
    digest_t      got;
    byte unsigned msg [$];
    int           len;
    bus_rstn    = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    errors      = 0;
    n_checks    = 0;
    test_no     = 0;
    errs_before = 0;
    last_err    = 1'b0;
    void'($urandom(SEED));
    repeat (5) @(posedge sha256_clk);
    #1;
    bus_rstn = 1'b1;

    check_word(word_t'(sys_ack_o), '0, "ack after reset");
    bus_read(`SHA256_OFS_CTRL, rd);
    check_word(rd, '0, "CTRL after reset");
    bus_read(`SHA256_OFS_SHA_CTRL, rd);
    check_word(rd, '0, "SHA_CTRL after reset");
    bus_read(`SHA256_OFS_FIFO_COUNT, rd);
    check_word(rd, '0, "FIFO count after reset");
    bus_read(`SHA256_OFS_VERSION, rd);
    check_word(rd, `SHA256_VERSION, "VERSION");
    bus_read(20'h00200, rd);                      // hole in the map
    check_word(rd, '0, "unmapped offset");
    finish_test("reset values");

    bus_write(`SHA256_OFS_CTRL, 32'hA5A5_0000);   // enable bit low
    bus_read(`SHA256_OFS_CTRL, rd);
    check_word(rd, 32'hA5A5_0000, "CTRL readback");
    bus_read(`SHA256_OFS_STATUS, rd);
    check_word(rd & 32'h1, '0, "STATUS enable bit");
    check_word(word_t'(activated_o), '0, "activated_o");
    bus_write(`SHA256_OFS_CTRL, 32'h1);
    bus_read(`SHA256_OFS_CTRL, rd);
    check_word(rd, 32'h1, "CTRL readback");
    bus_read(`SHA256_OFS_STATUS, rd);
    check_word(rd & 32'h1, 32'h1, "STATUS enable bit");
    check_word(word_t'(activated_o), 32'h1, "activated_o");
    bus_write(`SHA256_OFS_SHA_CTRL, 32'h0F0F_0003);
    bus_read(`SHA256_OFS_SHA_CTRL, rd);
    check_word(rd, 32'h0F0F_0001, "SHA_CTRL readback, reset bit hidden");
    bus_write(`SHA256_OFS_SHA_CTRL, '0);
    finish_test("control regs");

    msg = '{8'h61, 8'h62, 8'h63};
    hash_message(msg, "abc");
    finish_test("hash abc");

    len = MIN_LEN + int'($urandom % LEN_SPAN);
    msg = {};
    repeat (len) msg.push_back(8'($urandom));
    hash_message(msg, "random message");
    finish_test("hash random");

    // SHA enable low, the digest of the random message stays valid
    bus_write(`SHA256_OFS_SHA_CTRL, '0);
    // the engine buffer soaks up the first words, one per credit
    for (int i = 0; i < `SHA256_FIFO_DEPTH + `SHA256_CREDITS; i++) begin
      bus_write(`SHA256_OFS_SHA_PUSH, 32'hC0DE_0000 + i);
      check_word(word_t'(last_err), '0, "push error flag");
    end
    bus_read(`SHA256_OFS_FIFO_COUNT, rd);
    check_word(rd, `SHA256_FIFO_DEPTH, "FIFO count when full");
    bus_read(`SHA256_OFS_SHA_STATUS, rd);
    check_word(word_t'(rd[`SHA256_STAT_FIFO_FULL_BIT]), 32'h1, "full bit");
    bus_write(`SHA256_OFS_SHA_PUSH, 32'hDEAD_BEEF);
    check_word(word_t'(last_err), 32'h1, "error on push to full FIFO");
    bus_read(`SHA256_OFS_FIFO_COUNT, rd);
    check_word(rd, `SHA256_FIFO_DEPTH, "FIFO count after dropped push");
    finish_test("FIFO full");

    bus_write(`SHA256_OFS_SHA_CTRL, 32'h2);
    bus_read(`SHA256_OFS_SHA_CTRL, rd);           // covers the clear cycle
    check_word(rd, '0, "SHA_CTRL after reset bit");
    bus_read(`SHA256_OFS_FIFO_COUNT, rd);
    check_word(rd, '0, "FIFO count after clear");
    bus_read(`SHA256_OFS_SHA_STATUS, rd);
    check_word(word_t'(rd[`SHA256_STAT_FIFO_EMPTY_BIT]), 32'h1, "empty bit");
    check_word(word_t'(rd[`SHA256_STAT_HASH_VALID_BIT]), '0, "hash valid bit");
    read_digest(got);
    submit_digest(got, init_hash());
    finish_test("core reset");

    $display("%0d tests, %0d checks, %0d errors", test_no, n_checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
+incdir+dv
rtl/sha256_pkg.sv
rtl/sha256_push_if.sv
rtl/sha256_k_rom.sv
rtl/sha256_bus_regs.sv
rtl/sha256_msg_fifo.sv
rtl/sha256_engine.sv
rtl/sha256_top.sv
dv/tb_sha256_top.sv

// File: rtl/sha256_bus_regs.sv
`timescale 1ns/100ps
`include "sha256_defs.svh"

module sha256_bus_regs (
  input  logic                      sha256_clk,
  input  logic                      bus_rstn,
  input  logic [`SHA256_ADDR_W-1:0] sys_addr_i,
  input  sha256_pkg::word_t         sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  input  sha256_pkg::digest_t       digest_i,
  input  logic                      eng_ready_i,
  input  logic                      digest_valid_i,
  sha256_push_if.regs               push,
  output sha256_pkg::word_t         sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,
  output logic                      activated_o,
  output logic                      core_clear_o,
  output logic                      eng_enable_o
);
  import sha256_pkg::*;

  word_t     ctrl_q;        // global control
  word_t     sha_ctrl_q;    // SHA control
  word_t     status_w;
  word_t     sha_status_w;
  word_t     rdata_d;
  reg_addr_e addr;
  logic      glob_en;
  logic      sha_en;
  logic      push_req;      // write to the data push offset
  logic      fifo_empty;

  assign addr     = reg_addr_e'(sys_addr_i);
  assign glob_en  = ctrl_q[`SHA256_CTRL_ENABLE_BIT];
  assign sha_en   = sha_ctrl_q[`SHA256_CTRL_ENABLE_BIT];
  assign push_req = sys_wen_i && (addr == REG_SHA_PUSH);

  assign activated_o  = glob_en;
  assign eng_enable_o = glob_en && sha_en;   // only gates block start
  // the FIFO keeps its words while only the SHA enable is low
  assign core_clear_o = !glob_en || sha_ctrl_q[`SHA256_CTRL_RESET_BIT];

  // push goes straight to the FIFO so the count moves by the ack cycle
  assign push.push_valid = push_req && !push.fifo_full;
  assign push.push_data  = sys_wdata_i;

  assign fifo_empty = (push.fifo_count == '0);

  // ------------------------------
  // status words
  always_comb begin
    status_w     = '0;
    status_w[0]  = glob_en;
    status_w[4]  = eng_enable_o;
    sha_status_w = '0;
    sha_status_w[`SHA256_STAT_READY_BIT]      = eng_ready_i && fifo_empty;  // nothing left to hash
    sha_status_w[`SHA256_STAT_HASH_VALID_BIT] = digest_valid_i;
    sha_status_w[`SHA256_STAT_FIFO_EMPTY_BIT] = fifo_empty;
    sha_status_w[`SHA256_STAT_FIFO_FULL_BIT]  = push.fifo_full;
  end

  // read mux
  always_comb begin
    case (addr)
      REG_CTRL:       rdata_d = ctrl_q;
      REG_STATUS:     rdata_d = status_w;
      REG_VERSION:    rdata_d = `SHA256_VERSION;
      REG_SHA_CTRL: begin
        rdata_d = sha_ctrl_q;
        rdata_d[`SHA256_CTRL_RESET_BIT] = 1'b0;      // one shot, never seen
      end
      REG_SHA_STATUS: rdata_d = sha_status_w;
      REG_HASH_H7:    rdata_d = digest_i[7];
      REG_HASH_H6:    rdata_d = digest_i[6];
      REG_HASH_H5:    rdata_d = digest_i[5];
      REG_HASH_H4:    rdata_d = digest_i[4];
      REG_HASH_H3:    rdata_d = digest_i[3];
      REG_HASH_H2:    rdata_d = digest_i[2];
      REG_HASH_H1:    rdata_d = digest_i[1];
      REG_HASH_H0:    rdata_d = digest_i[0];
      REG_FIFO_COUNT: rdata_d = word_t'(push.fifo_count);
      default:        rdata_d = '0;                  // push offset and holes
    endcase
  end

  // ------------------------------
  // control registers
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
    end else begin
      sha_ctrl_q[`SHA256_CTRL_RESET_BIT] <= 1'b0;   // high for one cycle only
      if (sys_wen_i && addr == REG_CTRL)
        ctrl_q <= sys_wdata_i;
      if (sys_wen_i && addr == REG_SHA_CTRL)
        sha_ctrl_q <= sys_wdata_i;
    end
  end

  // bus response, one cycle after the request
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn) begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i || sys_ren_i;
      sys_err_o   <= push_req && push.fifo_full;    // word dropped
      sys_rdata_o <= sys_ren_i ? rdata_d : '0;
    end
  end

  // every ack answers a request of the cycle before
  a_ack_follows_req: assert property (@(posedge sha256_clk) disable iff (!bus_rstn)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

  // while full the fill level never grows, so no pushed word is stored
  a_no_push_when_full: assert property (@(posedge sha256_clk) disable iff (!bus_rstn)
    push.fifo_full |=> push.fifo_count <= $past(push.fifo_count));

endmodule

// File: rtl/sha256_defs.svh
`ifndef SHA256_DEFS_SVH
`define SHA256_DEFS_SVH

// ------------------------------
// sizes
`define SHA256_WORD_W        32            // bus and message word width
`define SHA256_ADDR_W        20            // decoded bus address bits
`define SHA256_FIFO_DEPTH    32            // message FIFO entries
`define SHA256_CREDITS       2             // words the engine can buffer
`define SHA256_BLOCK_WORDS   16
`define SHA256_ROUNDS        64

`define SHA256_VERSION       32'h16082811  // 0xYYMMDDss build code

// control register bits
`define SHA256_CTRL_ENABLE_BIT      0
`define SHA256_CTRL_RESET_BIT       1      // self clearing

// SHA status bits
`define SHA256_STAT_READY_BIT       0
`define SHA256_STAT_HASH_VALID_BIT  1
`define SHA256_STAT_FIFO_EMPTY_BIT  4
`define SHA256_STAT_FIFO_FULL_BIT   6

// ------------------------------
// byte offsets on the system bus
`define SHA256_OFS_CTRL        20'h00000
`define SHA256_OFS_STATUS      20'h00004
`define SHA256_OFS_VERSION     20'h0000C
`define SHA256_OFS_SHA_CTRL    20'h00100
`define SHA256_OFS_SHA_STATUS  20'h00104
`define SHA256_OFS_SHA_PUSH    20'h0010C
`define SHA256_OFS_HASH_H7     20'h00110   // H7 first, H0 last
`define SHA256_OFS_FIFO_COUNT  20'h00130

`endif

// File: rtl/sha256_engine.sv
`timescale 1ns/100ps
`include "sha256_defs.svh"

module sha256_engine (
  input  logic                sha256_clk,
  input  logic                bus_rstn,
  input  logic                core_clear_i,
  input  logic                eng_enable_i,     // gates block start only
  input  logic                word_valid_i,
  input  sha256_pkg::word_t   word_data_i,
  output logic                credit_return_o,
  output sha256_pkg::digest_t digest_o,
  output logic                eng_ready_o,
  output logic                digest_valid_o
);
  import sha256_pkg::*;

  localparam int RND_W = $clog2(`SHA256_ROUNDS);
  localparam digest_t H_INIT = {32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
                                32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667};

  eng_state_e       state;
  logic [RND_W-1:0] rnd;
  digest_t          hash_q;       // running digest
  digest_t          wv;           // working vars, index 0 is a
  word_t            w [16];       // schedule window, w[15] newest
  word_t            buf_q [2];    // word buffer, head at 0
  logic [1:0]       buf_cnt;
  logic [1:0]       wr_idx;
  logic             start;
  logic             step;
  logic             take;
  word_t            k_rnd;
  word_t            wt;
  word_t            t1;
  word_t            t2;

  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (`SHA256_WORD_W - n));
  endfunction

  sha256_k_rom k_rom_i (
    .round_i (rnd),
    .k_o     (k_rnd)
  );

  assign start  = (state == ENG_IDLE) && eng_enable_i && (buf_cnt != '0);
  assign take   = (state == ENG_ROUND) && (rnd < `SHA256_BLOCK_WORDS) && (buf_cnt != '0);
  assign step   = (state == ENG_ROUND) && ((rnd >= `SHA256_BLOCK_WORDS) || take);  // stall
  assign wr_idx = buf_cnt - 2'(take);

  assign credit_return_o = take;
  assign digest_o        = hash_q;
  // idle with nothing buffered or arriving
  assign eng_ready_o     = (state == ENG_IDLE) && (buf_cnt == '0) && !word_valid_i;

  // ------------------------------
  // round datapath
  always_comb begin
    if (rnd < `SHA256_BLOCK_WORDS)
      wt = buf_q[0];                                       // message word
    else
      wt = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9]
         + (rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
    t1 = wv[7] + (rotr(wv[4], 6) ^ rotr(wv[4], 11) ^ rotr(wv[4], 25))
       + ((wv[4] & wv[5]) ^ (~wv[4] & wv[6])) + k_rnd + wt;   // ch(e,f,g)
    t2 = (rotr(wv[0], 2) ^ rotr(wv[0], 13) ^ rotr(wv[0], 22))
       + ((wv[0] & wv[1]) ^ (wv[0] & wv[2]) ^ (wv[1] & wv[2])); // maj(a,b,c)
  end

  // buffer fill level
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn || core_clear_i)
      buf_cnt <= '0;
    else
      buf_cnt <= buf_cnt + 2'(word_valid_i) - 2'(take);
  end

  // buffer, schedule and working vars
  always_ff @(posedge sha256_clk) begin
    if (take)
      buf_q[0] <= buf_q[1];
    if (word_valid_i)
      buf_q[wr_idx[0]] <= word_data_i;     // overrides the shift when it lands at 0
    if (start)
      wv <= hash_q;
    else if (step) begin
      for (int i = 0; i < 15; i++)
        w[i] <= w[i+1];
      w[15] <= wt;
      wv    <= {wv[6:0], t1 + t2};         // a..h shift down
      wv[4] <= wv[3] + t1;                 // e = d + t1
    end
  end

  // ------------------------------
  // FSM
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn || core_clear_i) begin
      state          <= ENG_IDLE;
      rnd            <= '0;
      hash_q         <= H_INIT;
      digest_valid_o <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: if (start) begin
          state <= ENG_ROUND;
          rnd   <= '0;
        end
        ENG_ROUND: if (step) begin
          rnd <= rnd + 1'b1;                 // wraps to 0 after the last round
          if (rnd == RND_W'(`SHA256_ROUNDS - 1))
            state <= ENG_FINAL;
        end
        ENG_FINAL: begin
          for (int i = 0; i < 8; i++)
            hash_q[i] <= hash_q[i] + wv[i];
          digest_valid_o <= 1'b1;            // sticky until the next clear
          state          <= ENG_IDLE;
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // the credit link never delivers a word into a full buffer
  a_credit_rounds: assert property (@(posedge sha256_clk) disable iff (!bus_rstn || core_clear_i)
    word_valid_i |-> (buf_cnt != 2'd2) || take);

endmodule

// File: rtl/sha256_k_rom.sv
`timescale 1ns/100ps
`include "sha256_defs.svh"

module sha256_k_rom (
  input  logic [$clog2(`SHA256_ROUNDS)-1:0] round_i,
  output sha256_pkg::word_t                 k_o
);
  import sha256_pkg::*;

  // first 32 bits of the fractional cube roots of the first 64 primes
  localparam word_t k_tab [`SHA256_ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  assign k_o = k_tab[round_i];   // pure lookup, no clock

endmodule

// File: rtl/sha256_msg_fifo.sv
`timescale 1ns/100ps
`include "sha256_defs.svh"

module sha256_msg_fifo (
  input  logic              sha256_clk,
  input  logic              bus_rstn,
  input  logic              core_clear_i,
  input  logic              credit_return_i,  // engine took a word
  sha256_push_if.fifo       push,
  output logic              word_valid_o,
  output sha256_pkg::word_t word_data_o
);
  import sha256_pkg::*;

  localparam int PTR_W = $clog2(`SHA256_FIFO_DEPTH);
  localparam int CRD_W = $clog2(`SHA256_CREDITS + 1);

  word_t            mem [`SHA256_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_cnt_t        count;
  logic [CRD_W-1:0] credits;   // free slots in the engine buffer
  logic             send;

  assign send            = (count != '0) && (credits != '0);
  assign push.fifo_count = count;
  assign push.fifo_full  = (count == fifo_cnt_t'(`SHA256_FIFO_DEPTH));

  // ------------------------------
  // pointers, fill level and credits
  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn || core_clear_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credits      <= CRD_W'(`SHA256_CREDITS);
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= send;                        // one cycle pulse per word
      if (push.push_valid)
        wr_ptr <= wr_ptr + 1'b1;                   // wraps at depth
      if (send)
        rd_ptr <= rd_ptr + 1'b1;
      count   <= count + fifo_cnt_t'(push.push_valid) - fifo_cnt_t'(send);
      credits <= credits + CRD_W'(credit_return_i) - CRD_W'(send);
    end
  end

  // storage and output word
  always_ff @(posedge sha256_clk) begin
    if (push.push_valid)
      mem[wr_ptr] <= push.push_data;
    if (send)
      word_data_o <= mem[rd_ptr];
  end

  // engine never hands back more credits than it was given
  a_credit_bound: assert property (@(posedge sha256_clk) disable iff (!bus_rstn)
    credits <= CRD_W'(`SHA256_CREDITS));

  // no write lands on a full FIFO
  a_no_overflow: assert property (@(posedge sha256_clk) disable iff (!bus_rstn)
    count <= fifo_cnt_t'(`SHA256_FIFO_DEPTH));

endmodule

// File: rtl/sha256_pkg.sv
`include "sha256_defs.svh"

package sha256_pkg;

  typedef logic [`SHA256_WORD_W-1:0] word_t;                // one bus or message word
  typedef word_t [7:0] digest_t;                            // index 0 holds H0
  typedef logic [$clog2(`SHA256_FIFO_DEPTH):0] fifo_cnt_t;  // counts 0 up to the full depth

  // ------------------------------
  // register map
  typedef enum logic [`SHA256_ADDR_W-1:0] {
    REG_CTRL       = `SHA256_OFS_CTRL,
    REG_STATUS     = `SHA256_OFS_STATUS,
    REG_VERSION    = `SHA256_OFS_VERSION,
    REG_SHA_CTRL   = `SHA256_OFS_SHA_CTRL,
    REG_SHA_STATUS = `SHA256_OFS_SHA_STATUS,
    REG_SHA_PUSH   = `SHA256_OFS_SHA_PUSH,    // write only
    REG_HASH_H7    = `SHA256_OFS_HASH_H7,
    REG_HASH_H6    = `SHA256_OFS_HASH_H7 + 20'h04,
    REG_HASH_H5    = `SHA256_OFS_HASH_H7 + 20'h08,
    REG_HASH_H4    = `SHA256_OFS_HASH_H7 + 20'h0C,
    REG_HASH_H3    = `SHA256_OFS_HASH_H7 + 20'h10,
    REG_HASH_H2    = `SHA256_OFS_HASH_H7 + 20'h14,
    REG_HASH_H1    = `SHA256_OFS_HASH_H7 + 20'h18,
    REG_HASH_H0    = `SHA256_OFS_HASH_H7 + 20'h1C,
    REG_FIFO_COUNT = `SHA256_OFS_FIFO_COUNT
  } reg_addr_e;

  // engine FSM
  typedef enum logic [1:0] {
    ENG_IDLE,     // waiting for the first word of a block
    ENG_ROUND,    // one compression round per cycle
    ENG_FINAL     // add working vars into the digest
  } eng_state_e;

endpackage

// File: rtl/sha256_push_if.sv
`timescale 1ns/100ps

// push path between register block and message FIFO
interface sha256_push_if;
  import sha256_pkg::*;

  logic      push_valid;   // one word stored per cycle
  word_t     push_data;
  logic      fifo_full;    // push_valid must stay low while set
  fifo_cnt_t fifo_count;   // current fill level

  // register side
  modport regs (
    output push_valid,
    output push_data,
    input  fifo_full,
    input  fifo_count
  );

  // FIFO side
  modport fifo (
    input  push_valid,
    input  push_data,
    output fifo_full,
    output fifo_count
  );

endinterface

// File: rtl/sha256_top.sv
`timescale 1ns/100ps
`include "sha256_defs.svh"

module sha256_top (
  input  logic                      sha256_clk,
  input  logic                      bus_rstn,     // sync, active low

  input  logic [`SHA256_ADDR_W-1:0] sys_addr_i,
  input  sha256_pkg::word_t         sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output sha256_pkg::word_t         sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,

  output logic                      activated_o   // global enable
);
  import sha256_pkg::*;

  logic    core_clear;
  logic    eng_enable;
  logic    word_valid;
  word_t   word_data;
  logic    credit_return;
  digest_t digest;
  logic    eng_ready;
  logic    digest_valid;

  sha256_push_if push_if_i ();

  sha256_bus_regs regs_i (
    .sha256_clk     (sha256_clk),
    .bus_rstn       (bus_rstn),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .digest_i       (digest),
    .eng_ready_i    (eng_ready),
    .digest_valid_i (digest_valid),
    .push           (push_if_i.regs),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .sys_err_o      (sys_err_o),
    .activated_o    (activated_o),
    .core_clear_o   (core_clear),
    .eng_enable_o   (eng_enable)
  );

  sha256_msg_fifo fifo_i (
    .sha256_clk      (sha256_clk),
    .bus_rstn        (bus_rstn),
    .core_clear_i    (core_clear),
    .credit_return_i (credit_return),
    .push            (push_if_i.fifo),
    .word_valid_o    (word_valid),
    .word_data_o     (word_data)
  );

  sha256_engine engine_i (
    .sha256_clk      (sha256_clk),
    .bus_rstn        (bus_rstn),
    .core_clear_i    (core_clear),
    .eng_enable_i    (eng_enable),
    .word_valid_i    (word_valid),
    .word_data_i     (word_data),
    .credit_return_o (credit_return),
    .digest_o        (digest),
    .eng_ready_o     (eng_ready),
    .digest_valid_o  (digest_valid)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the SHA-256 testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f flist.f --top-module tb_sha256_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sha256_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# pass only if the testbench printed its pass line
if grep -qx "Everything OK" "$LOG"; then
  exit 0
fi
exit 1
